/* source/rv_pkg.sv */
// rv_pkg: shared widths, opcodes, ALU operations and pipeline structs for the RV32I core
package rv_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;       // Data or byte address
    typedef logic [4:0]      reg_addr_t;   // Register index
    typedef logic [29:0]     cache_addr_t; // Word address on cache ports
    typedef logic [6:0]      opcode_t;

    localparam opcode_t op_reg   = 7'b0110011;
    localparam opcode_t op_imm   = 7'b0010011;
    localparam opcode_t op_load  = 7'b0000011;
    localparam opcode_t op_store = 7'b0100011;

    localparam word_t nop_inst = 32'h0000_0013; // ADDI x0,x0,0

    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_xor = 4'd4,
        alu_sll = 4'd5,
        alu_srl = 4'd6,
        alu_sra = 4'd7,
        alu_slt = 4'd8
    } alu_op_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_to_reg; // Load result goes to rd
        logic    mem_write;
        logic    use_imm;    // Operand b from immediate
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;
    } dec_t;

    // Write-back bus, also the forwarding source
    typedef struct packed {
        logic      reg_write;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

endpackage

/* source/fetch_unit.sv */
// fetch_unit: program counter, I-cache address and IF/ID instruction register
`timescale 1ns/1ps

module fetch_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stall,
    input  logic                load_use_hold,
    input  rv_pkg::word_t       ICACHE_rdata,
    output rv_pkg::cache_addr_t ICACHE_addr,
    output rv_pkg::word_t       PC,
    output rv_pkg::word_t       inst
);

    rv_pkg::word_t fetched; // Instruction in register byte order
    logic          advance;

    assign ICACHE_addr = PC[31:2];
    assign fetched     = {<<8{ICACHE_rdata}}; // Bus is big-endian per byte
    assign advance     = !stall && !load_use_hold;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            PC   <= '0;
            inst <= rv_pkg::nop_inst; // Pipeline starts empty
        end else if (advance) begin
            PC   <= PC + 32'd4;
            inst <= fetched;
        end
    end

endmodule

/* source/inst_decoder.sv */
// inst_decoder: turns the IF/ID instruction into control fields and an immediate
`timescale 1ns/1ps

module inst_decoder (
    input  rv_pkg::word_t inst,
    output rv_pkg::dec_t  dec
);

    rv_pkg::opcode_t opcode;
    logic [2:0]      funct3;
    logic            is_shift;
    rv_pkg::word_t   i_imm;
    rv_pkg::word_t   s_imm;

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101);
    assign i_imm    = {{20{inst[31]}}, inst[31:20]};
    assign s_imm    = {{20{inst[31]}}, inst[31:25], inst[11:7]};

    // alt is bit 30, picks SUB or SRA
    function automatic rv_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        rv_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
            3'b001:  op = rv_pkg::alu_sll;
            3'b010:  op = rv_pkg::alu_slt;
            3'b100:  op = rv_pkg::alu_xor;
            3'b101:  op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110:  op = rv_pkg::alu_or;
            3'b111:  op = rv_pkg::alu_and;
            default: op = rv_pkg::alu_add; // SLTU not in subset
        endcase
        return op;
    endfunction

    always_comb begin
        dec.ctrl = '0;
        dec.rs1  = inst[19:15];
        dec.rs2  = inst[24:20];
        dec.rd   = inst[11:7];
        dec.imm  = '0;

        case (opcode)
            rv_pkg::op_reg: begin
                dec.ctrl.reg_write = 1'b1;
                dec.ctrl.alu_op    = alu_sel(funct3, inst[30]);
            end
            rv_pkg::op_imm: begin
                dec.ctrl.reg_write = 1'b1;
                dec.ctrl.use_imm   = 1'b1;
                dec.ctrl.alu_op    = alu_sel(funct3, inst[30] && is_shift); // ADDI has no SUB
                dec.imm            = is_shift ? {27'd0, inst[24:20]} : i_imm; // shamt
            end
            rv_pkg::op_load: begin
                dec.ctrl.reg_write  = 1'b1;
                dec.ctrl.mem_to_reg = 1'b1;
                dec.ctrl.use_imm    = 1'b1;
                dec.ctrl.alu_op     = rv_pkg::alu_add; // Address = rs1 + imm
                dec.imm             = i_imm;
            end
            rv_pkg::op_store: begin
                dec.ctrl.mem_write = 1'b1;
                dec.ctrl.use_imm   = 1'b1;
                dec.ctrl.alu_op    = rv_pkg::alu_add;
                dec.imm            = s_imm;
            end
            default: begin
                dec.ctrl = '0; // Unknown opcode acts as bubble
            end
        endcase
    end

endmodule

/* source/reg_file.sv */
// reg_file: 32 x 32-bit integer registers, two read ports with write-back bypass
`timescale 1ns/1ps

module reg_file (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    input  rv_pkg::wb_t       wb,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data
);

    rv_pkg::word_t regs [32];
    logic          wr_en;

    assign wr_en = wb.reg_write && (wb.rd != '0); // x0 is never written

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Same-cycle write shows up on the read port
    assign rs1_data = (wr_en && wb.rd == rs1) ? wb.data : regs[rs1];
    assign rs2_data = (wr_en && wb.rd == rs2) ? wb.data : regs[rs2];

endmodule

/* source/alu.sv */
// alu: combinational integer ALU for the nine supported operations
`timescale 1ns/1ps

module alu (
    input  rv_pkg::alu_op_e op,
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    output rv_pkg::word_t   result
);

    logic [4:0] shamt;
    logic       less;

    assign shamt = b[4:0];
    assign less  = $signed(a) < $signed(b); // SLT is signed

    always_comb begin
        case (op)
            rv_pkg::alu_add: result = a + b;
            rv_pkg::alu_sub: result = a - b;
            rv_pkg::alu_and: result = a & b;
            rv_pkg::alu_or:  result = a | b;
            rv_pkg::alu_xor: result = a ^ b;
            rv_pkg::alu_sll: result = a << shamt;
            rv_pkg::alu_srl: result = a >> shamt;
            rv_pkg::alu_sra: result = $signed(a) >>> shamt;
            rv_pkg::alu_slt: result = {{(rv_pkg::xlen-1){1'b0}}, less};
            default:         result = '0;
        endcase
    end

endmodule

/* source/execute_stage.sv */
// execute_stage: ID/EX register, load-use check, operand forwarding, ALU and EX/MEM register
`timescale 1ns/1ps

module execute_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    input  rv_pkg::dec_t      dec,
    input  rv_pkg::word_t     rs1_data,
    input  rv_pkg::word_t     rs2_data,
    input  rv_pkg::wb_t       wb,
    output logic              load_use_hold,
    output rv_pkg::ctrl_t     ex_ctrl,
    output rv_pkg::reg_addr_t ex_rd,
    output rv_pkg::word_t     ex_result,
    output rv_pkg::word_t     ex_store_data
);

    rv_pkg::ctrl_t     id_ctrl;
    rv_pkg::reg_addr_t id_rs1;
    rv_pkg::reg_addr_t id_rs2;
    rv_pkg::reg_addr_t id_rd;
    rv_pkg::word_t     id_imm;
    rv_pkg::word_t     id_rs1_data;
    rv_pkg::word_t     id_rs2_data;

    rv_pkg::word_t fwd_a;
    rv_pkg::word_t fwd_b;
    rv_pkg::word_t alu_b;
    rv_pkg::word_t alu_result;
    logic          mem_fwd_ok; // EX/MEM holds a live write
    logic          wb_fwd_ok;

    // Load in EX feeding the instruction in decode
    assign load_use_hold = id_ctrl.mem_to_reg && (id_rd != '0)
                           && ((id_rd == dec.rs1) || (id_rd == dec.rs2));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ctrl <= '0;
        end else if (!stall) begin
            id_ctrl <= load_use_hold ? '0 : dec.ctrl; // Bubble on hazard
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            id_rs1      <= dec.rs1;
            id_rs2      <= dec.rs2;
            id_rd       <= dec.rd;
            id_imm      <= dec.imm;
            id_rs1_data <= rs1_data;
            id_rs2_data <= rs2_data;
        end
    end

    assign mem_fwd_ok = ex_ctrl.reg_write && (ex_rd != '0);
    assign wb_fwd_ok  = wb.reg_write && (wb.rd != '0);

    // Youngest producer wins
    always_comb begin
        if (mem_fwd_ok && ex_rd == id_rs1) begin
            fwd_a = ex_result;
        end else if (wb_fwd_ok && wb.rd == id_rs1) begin
            fwd_a = wb.data;
        end else begin
            fwd_a = id_rs1_data;
        end

        if (mem_fwd_ok && ex_rd == id_rs2) begin
            fwd_b = ex_result;
        end else if (wb_fwd_ok && wb.rd == id_rs2) begin
            fwd_b = wb.data;
        end else begin
            fwd_b = id_rs2_data;
        end
    end

    assign alu_b = id_ctrl.use_imm ? id_imm : fwd_b;

    alu u_alu (
        .op     (id_ctrl.alu_op),
        .a      (fwd_a),
        .b      (alu_b),
        .result (alu_result)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_ctrl <= '0;
        end else if (!stall) begin
            ex_ctrl <= id_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_rd         <= id_rd;
            ex_result     <= alu_result;
            ex_store_data <= fwd_b; // SW data, forwarded
        end
    end

endmodule

/* source/mem_writeback.sv */
// mem_writeback: D-cache drive, MEM/WB register and write-back select
`timescale 1ns/1ps

module mem_writeback (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stall,
    input  rv_pkg::ctrl_t       ex_ctrl,
    input  rv_pkg::reg_addr_t   ex_rd,
    input  rv_pkg::word_t       ex_result,
    input  rv_pkg::word_t       ex_store_data,
    input  rv_pkg::word_t       DCACHE_rdata,
    output logic                DCACHE_ren,
    output logic                DCACHE_wen,
    output rv_pkg::cache_addr_t DCACHE_addr,
    output rv_pkg::word_t       DCACHE_wdata,
    output rv_pkg::wb_t         wb
);

    rv_pkg::word_t     load_data;
    logic              mw_reg_write;
    logic              mw_mem_to_reg;
    rv_pkg::reg_addr_t mw_rd;
    rv_pkg::word_t     mw_result;
    rv_pkg::word_t     mw_load;

    assign DCACHE_ren   = !ex_ctrl.mem_write; // Read unless storing
    assign DCACHE_wen   = ex_ctrl.mem_write;
    assign DCACHE_addr  = ex_result[31:2];
    assign DCACHE_wdata = {<<8{ex_store_data}}; // To bus byte order
    assign load_data    = {<<8{DCACHE_rdata}};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mw_reg_write  <= 1'b0;
            mw_mem_to_reg <= 1'b0;
        end else if (!stall) begin
            mw_reg_write  <= ex_ctrl.reg_write;
            mw_mem_to_reg <= ex_ctrl.mem_to_reg;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            mw_rd     <= ex_rd;
            mw_result <= ex_result;
            mw_load   <= load_data;
        end
    end

    always_comb begin
        wb.reg_write = mw_reg_write;
        wb.rd        = mw_rd;
        wb.data      = mw_mem_to_reg ? mw_load : mw_result; // Load or ALU
    end

endmodule

/* source/rv_core.sv */
// rv_core: five-stage in-order RV32I subset pipeline with I-cache and D-cache ports
`timescale 1ns/1ps

module rv_core (
    input  logic                clk,
    input  logic                rst_n,
    output logic                ICACHE_ren,
    output rv_pkg::cache_addr_t ICACHE_addr,
    input  logic                ICACHE_stall,
    input  rv_pkg::word_t       ICACHE_rdata,
    output logic                DCACHE_ren,
    output logic                DCACHE_wen,
    output rv_pkg::cache_addr_t DCACHE_addr,
    output rv_pkg::word_t       DCACHE_wdata,
    input  logic                DCACHE_stall,
    input  rv_pkg::word_t       DCACHE_rdata,
    output rv_pkg::word_t       PC
);

    logic              stall;
    logic              load_use_hold;
    rv_pkg::word_t     inst;
    rv_pkg::dec_t      dec;
    rv_pkg::word_t     rs1_data;
    rv_pkg::word_t     rs2_data;
    rv_pkg::wb_t       wb;
    rv_pkg::ctrl_t     ex_ctrl;
    rv_pkg::reg_addr_t ex_rd;
    rv_pkg::word_t     ex_result;
    rv_pkg::word_t     ex_store_data;

    assign stall      = ICACHE_stall || DCACHE_stall; // Freezes every stage
    assign ICACHE_ren = 1'b1;

    fetch_unit u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .load_use_hold (load_use_hold),
        .ICACHE_rdata  (ICACHE_rdata),
        .ICACHE_addr   (ICACHE_addr),
        .PC            (PC),
        .inst          (inst)
    );

    inst_decoder u_decoder (
        .inst (inst),
        .dec  (dec)
    );

    reg_file u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (inst[19:15]),
        .rs2      (inst[24:20]),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    execute_stage u_execute (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .dec           (dec),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .wb            (wb),
        .load_use_hold (load_use_hold),
        .ex_ctrl       (ex_ctrl),
        .ex_rd         (ex_rd),
        .ex_result     (ex_result),
        .ex_store_data (ex_store_data)
    );

    mem_writeback u_mem_wb (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .ex_ctrl       (ex_ctrl),
        .ex_rd         (ex_rd),
        .ex_result     (ex_result),
        .ex_store_data (ex_store_data),
        .DCACHE_rdata  (DCACHE_rdata),
        .DCACHE_ren    (DCACHE_ren),
        .DCACHE_wen    (DCACHE_wen),
        .DCACHE_addr   (DCACHE_addr),
        .DCACHE_wdata  (DCACHE_wdata),
        .wb            (wb)
    );

endmodule

/* tests/tb_checker.sv */
// tb_checker: instruction-set model of the program, store and load address compare, timeout
`timescale 1ns/1ps

module tb_checker #(
    parameter int prog_len  = 1,
    parameter int mem_words = 128
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                prog_ready,
    input  rv_pkg::word_t       PC,
    input  logic                ICACHE_ren,
    input  rv_pkg::cache_addr_t ICACHE_addr,
    input  logic                ICACHE_stall,
    input  logic                DCACHE_ren,
    input  logic                DCACHE_wen,
    input  rv_pkg::cache_addr_t DCACHE_addr,
    input  rv_pkg::word_t       DCACHE_wdata,
    input  logic                DCACHE_stall,
    input  rv_pkg::ctrl_t       mem_ctrl, // EX/MEM control inside the DUT
    output logic                run_done,
    output int                  mismatches,
    output int                  failures
);

    localparam int max_cycles   = 4 * (prog_len + 40);
    localparam int drain_cycles = 8; // Quiet cycles after the last store

    rv_pkg::word_t       regs [32];
    rv_pkg::word_t       mem [mem_words]; // Port byte order
    rv_pkg::cache_addr_t exp_store_addr [$];
    rv_pkg::word_t       exp_store_data [$];
    rv_pkg::cache_addr_t exp_load_addr [$];
    int                  stores_seen;
    int                  loads_seen;
    int                  cycles;
    int                  drain;
    logic                model_ready;
    logic                reset_seen;
    logic                last_stall;
    rv_pkg::word_t       last_pc;

    function automatic rv_pkg::word_t swap_bytes(input rv_pkg::word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // RV32I semantics by funct3, alt is instruction bit 30
    function automatic rv_pkg::word_t ref_alu(input logic [2:0] f3, input logic alt,
                                              input rv_pkg::word_t a, input rv_pkg::word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic run_model();
        rv_pkg::word_t inst;
        rv_pkg::word_t a;
        rv_pkg::word_t b;
        rv_pkg::word_t addr;
        rv_pkg::word_t i_imm;
        rv_pkg::word_t result;
        logic [2:0]    f3;
        logic          writes;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = tb_top.dmem[i];
        end
        for (int i = 0; i < prog_len; i++) begin
            inst   = swap_bytes(tb_top.imem[i]);
            f3     = inst[14:12];
            a      = regs[inst[19:15]];
            b      = regs[inst[24:20]];
            i_imm  = {{20{inst[31]}}, inst[31:20]};
            writes = 1'b1;
            case (inst[6:0])
                rv_pkg::op_reg: result = ref_alu(f3, inst[30], a, b);
                rv_pkg::op_imm: result = ref_alu(f3, inst[30] && f3 == 3'd5, a, i_imm);
                rv_pkg::op_load: begin
                    addr   = a + i_imm;
                    result = swap_bytes(mem[addr[8:2]]);
                    exp_load_addr.push_back(addr[31:2]);
                end
                rv_pkg::op_store: begin
                    addr   = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
                    writes = 1'b0;
                    mem[addr[8:2]] = swap_bytes(b);
                    exp_store_addr.push_back(addr[31:2]);
                    exp_store_data.push_back(swap_bytes(b));
                end
                default: writes = 1'b0;
            endcase
            if (writes && inst[11:7] != 5'd0) begin
                regs[inst[11:7]] = result;
            end
        end
        model_ready = 1'b1;
    endtask

    task automatic compare_word(input string name, input rv_pkg::word_t expected,
                                input rv_pkg::word_t actual);
        if (actual !== expected) begin
            mismatches++;
            $display("MISMATCH %s expected %08h actual %08h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    task automatic check_idle(input string name);
        compare_word({name, "_pc"}, '0, PC);
        compare_word({name, "_icache_addr"}, '0, {2'b00, ICACHE_addr});
        compare_word({name, "_dcache_wen"}, 32'd0, {31'd0, DCACHE_wen});
        compare_word({name, "_dcache_ren"}, 32'd1, {31'd0, DCACHE_ren});
        compare_word({name, "_icache_ren"}, 32'd1, {31'd0, ICACHE_ren});
    endtask

    task automatic watch_cycle();
        if (last_stall && PC !== last_pc) begin
            failures++;
            $display("PC changed from %08h to %08h over a stalled cycle", last_pc, PC);
        end
        compare_word("icache_addr", {2'b00, PC[31:2]}, {2'b00, ICACHE_addr}); // Word index
        if (ICACHE_stall || DCACHE_stall) begin
            return; // Nothing leaves EX/MEM this cycle
        end
        if (DCACHE_wen === 1'b1) begin
            if (stores_seen < exp_store_addr.size()) begin
                compare_word("store_addr", {2'b00, exp_store_addr[stores_seen]},
                             {2'b00, DCACHE_addr});
                compare_word("store_data", exp_store_data[stores_seen], DCACHE_wdata);
            end else begin
                failures++;
                $display("Store to %08h beyond the expected sequence", DCACHE_addr);
            end
            stores_seen++;
        end
        if (mem_ctrl.mem_to_reg === 1'b1) begin
            if (loads_seen < exp_load_addr.size()) begin
                compare_word("load_addr", {2'b00, exp_load_addr[loads_seen]},
                             {2'b00, DCACHE_addr});
            end else begin
                failures++;
                $display("Load from %08h beyond the expected sequence", DCACHE_addr);
            end
            loads_seen++;
        end
        if (stores_seen >= exp_store_addr.size()) begin
            drain++;
            if (drain >= drain_cycles) begin
                if (loads_seen != exp_load_addr.size()) begin
                    failures++;
                    $display("Saw %0d loads but the program has %0d", loads_seen,
                             exp_load_addr.size());
                end
                run_done = 1'b1;
            end
        end
    endtask

    initial begin
        run_done    = 1'b0;
        mismatches  = 0;
        failures    = 0;
        stores_seen = 0;
        loads_seen  = 0;
        cycles      = 0;
        drain       = 0;
        model_ready = 1'b0;
        reset_seen  = 1'b0;
        last_stall  = 1'b0;
        last_pc     = '0;
        wait (prog_ready === 1'b1);
        run_model();
    end

    // Samples at the rising edge, before the DUT registers update
    always @(posedge clk) begin
        if (model_ready && !run_done) begin
            cycles++;
            if (!rst_n) begin
                if (cycles > 1) begin
                    check_idle("reset");
                end
            end else if (!reset_seen) begin
                check_idle("after_reset");
                reset_seen = 1'b1;
            end else begin
                watch_cycle();
            end
            last_stall = ICACHE_stall || DCACHE_stall;
            last_pc    = PC;
            if (!run_done && cycles >= max_cycles) begin
                failures++;
                $display("Timeout after %0d cycles with %0d of %0d stores seen",
                         cycles, stores_seen, exp_store_addr.size());
                run_done = 1'b1;
            end
        end
    end

endmodule

/* tests/tb_top.sv */
// tb_top: clock, reset, random program and data, cache models and DUT for rv_core
`timescale 1ns/1ps

module tb_top;

    localparam int n_random  = 200;
    localparam int prog_len  = n_random + 31 + 8; // Body, register dump, NOP tail
    localparam int mem_words = 128;               // Random data, then dump area

    logic                clk;
    logic                rst_n;
    logic                prog_ready;
    logic                ICACHE_ren;
    rv_pkg::cache_addr_t ICACHE_addr;
    logic                ICACHE_stall;
    rv_pkg::word_t       ICACHE_rdata;
    logic                DCACHE_ren;
    logic                DCACHE_wen;
    rv_pkg::cache_addr_t DCACHE_addr;
    rv_pkg::word_t       DCACHE_wdata;
    logic                DCACHE_stall;
    rv_pkg::word_t       DCACHE_rdata;
    rv_pkg::word_t       PC;
    logic                run_done;
    int                  mismatches;
    int                  failures;
    logic [31:0]         lfsr_state;
    rv_pkg::word_t       imem [prog_len];  // Port byte order
    rv_pkg::word_t       dmem [mem_words]; // Port byte order

    function automatic rv_pkg::word_t swap_bytes(input rv_pkg::word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic rv_pkg::word_t fill_word(input rv_pkg::cache_addr_t a);
        return {a, 2'b00} ^ 32'hd00d_0000;
    endfunction

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            bits       = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
        end
        return bits;
    endfunction

    task automatic build_program();
        rv_pkg::word_t     inst;
        logic [3:0]        kind;
        logic [2:0]        f3;
        logic              alt;
        logic [5:0]        word_sel;
        logic [11:0]       imm;
        rv_pkg::reg_addr_t rd;
        rv_pkg::reg_addr_t rs1;
        rv_pkg::reg_addr_t rs2;
        rv_pkg::reg_addr_t prev_rd;
        prev_rd = '0;
        for (int i = 0; i < n_random; i++) begin
            kind     = 4'(take_bits(4));
            rd       = 5'(take_bits(5));
            rs1      = 5'(take_bits(5));
            rs2      = 5'(take_bits(5));
            f3       = 3'(take_bits(3));
            f3       = (f3 == 3'd3) ? 3'd0 : f3; // No SLTU
            alt      = 1'(take_bits(1)) && (f3 == 3'd5 || (kind < 4'd7 && f3 == 3'd0));
            word_sel = 6'(take_bits(6));
            if (1'(take_bits(1))) begin // Depend on the last result
                if (kind >= 4'd14) begin
                    rs2 = prev_rd;
                end else begin
                    rs1 = prev_rd;
                end
            end
            if (kind < 4'd7) begin
                inst = {1'b0, alt, 5'd0, rs2, rs1, f3, rd, rv_pkg::op_reg};
            end else if (kind < 4'd12) begin
                imm  = (f3 == 3'd1 || f3 == 3'd5) ? {1'b0, alt, 5'd0, rs2} : 12'(take_bits(12));
                inst = {imm, rs1, f3, rd, rv_pkg::op_imm};
            end else if (kind < 4'd14) begin
                imm  = {4'd0, word_sel, 2'b00}; // Base x0, 0 to 252
                inst = {imm, 5'd0, 3'b010, rd, rv_pkg::op_load};
            end else begin
                imm  = {4'd0, word_sel, 2'b00};
                inst = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], rv_pkg::op_store};
            end
            if (kind < 4'd14) begin
                prev_rd = rd;
            end
            imem[i] = swap_bytes(inst);
        end
        for (int r = 1; r < 32; r++) begin
            imm  = 12'(256 + 4 * (r - 1)); // Dump x1..x31 from 256
            inst = {imm[11:5], 5'(r), 5'd0, 3'b010, imm[4:0], rv_pkg::op_store};
            imem[n_random + r - 1] = swap_bytes(inst);
        end
        for (int i = n_random + 31; i < prog_len; i++) begin
            imem[i] = swap_bytes(rv_pkg::nop_inst);
        end
    endtask

    task automatic build_memory();
        for (int i = 0; i < mem_words; i++) begin
            dmem[i] = (i < 64) ? take_bits(32) : fill_word(30'(i));
        end
    endtask

    always #20 clk = ~clk;

    // Cache models, both answer in the same cycle
    assign ICACHE_rdata = (ICACHE_addr < prog_len) ? imem[ICACHE_addr[7:0]]
                                                   : swap_bytes(rv_pkg::nop_inst);
    assign DCACHE_rdata = (DCACHE_addr < mem_words) ? dmem[DCACHE_addr[6:0]]
                                                    : fill_word(DCACHE_addr);

    always @(posedge clk) begin
        if (DCACHE_wen === 1'b1 && !DCACHE_stall && DCACHE_addr < mem_words) begin
            dmem[DCACHE_addr[6:0]] <= DCACHE_wdata;
        end
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        ICACHE_stall = 1'b0;
        DCACHE_stall = 1'b0;
        prog_ready   = 1'b0;
        lfsr_state   = 32'h0dfb_e109;
        build_program();
        build_memory();
        prog_ready   = 1'b1;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        forever begin
            @(negedge clk);
            ICACHE_stall = (3'(take_bits(3)) == 3'd0); // 1 in 8
            DCACHE_stall = (3'(take_bits(3)) == 3'd0);
        end
    end

    rv_core dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .ICACHE_ren   (ICACHE_ren),
        .ICACHE_addr  (ICACHE_addr),
        .ICACHE_stall (ICACHE_stall),
        .ICACHE_rdata (ICACHE_rdata),
        .DCACHE_ren   (DCACHE_ren),
        .DCACHE_wen   (DCACHE_wen),
        .DCACHE_addr  (DCACHE_addr),
        .DCACHE_wdata (DCACHE_wdata),
        .DCACHE_stall (DCACHE_stall),
        .DCACHE_rdata (DCACHE_rdata),
        .PC           (PC)
    );

    tb_checker #(
        .prog_len  (prog_len),
        .mem_words (mem_words)
    ) u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .prog_ready   (prog_ready),
        .PC           (PC),
        .ICACHE_ren   (ICACHE_ren),
        .ICACHE_addr  (ICACHE_addr),
        .ICACHE_stall (ICACHE_stall),
        .DCACHE_ren   (DCACHE_ren),
        .DCACHE_wen   (DCACHE_wen),
        .DCACHE_addr  (DCACHE_addr),
        .DCACHE_wdata (DCACHE_wdata),
        .DCACHE_stall (DCACHE_stall),
        .mem_ctrl     (dut.ex_ctrl),
        .run_done     (run_done),
        .mismatches   (mismatches),
        .failures     (failures)
    );

    initial begin
        wait (run_done === 1'b1);
        $display("Error counts: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* all.f */
source/rv_pkg.sv
source/fetch_unit.sv
source/inst_decoder.sv
source/reg_file.sv
source/alu.sv
source/execute_stage.sv
source/mem_writeback.sv
source/rv_core.sv
tests/tb_checker.sv
tests/tb_top.sv
